// ==== bt_payload_rx.f ====
common/bt_payload_pkg.sv
common/payload_bit_if.sv
pypro/payload_pypro.sv
hw/payload_bit_ctrl.sv
fhs/fhs_decoder.sv
hw/payload_regs.sv
hw/bt_payload_rx.sv
testbench/tb_bt_payload_rx.sv

// ==== common/bt_payload_pkg.sv ====
package bt_payload_pkg;

  ////////////////////
  // field types
  ////////////////////

  // bit counts and lengths in bits
  typedef logic [12:0] bit_len_t;
  // payload header length in bytes
  typedef logic [9:0]  pylen_byte_t;
  typedef logic [1:0]  llid_t;
  typedef logic [6:0]  whiten_seed_t;

  // device address parts
  typedef logic [23:0] bd_lap_t;
  typedef logic [7:0]  bd_uap_t;
  typedef logic [15:0] bd_nap_t;

  typedef logic [23:0] cod_t;
  typedef logic [2:0]  lt_addr_t;
  // native clock bits 27..2
  typedef logic [25:0] fhs_clk_t;

  ////////////////////
  // register map
  ////////////////////

  localparam logic [7:0] REG_CTRL        = 8'h00;
  localparam logic [7:0] REG_LEN         = 8'h04;
  localparam logic [7:0] REG_STATUS      = 8'h08;
  localparam logic [7:0] REG_FHS_LAP     = 8'h0C;
  localparam logic [7:0] REG_FHS_UAP_NAP = 8'h10;
  localparam logic [7:0] REG_FHS_COD     = 8'h14;
  localparam logic [7:0] REG_FHS_LT_CLK  = 8'h18;

  // payload constants
  localparam int CRC_BITS = 16;
  localparam int FHS_BITS = 144;

endpackage

// ==== common/payload_bit_if.sv ====
`timescale 1ns/1ps

// decoded bit stream, one bit per strobe, no handshake
interface payload_bit_if;
  import bt_payload_pkg::*;

  logic     bit_strobe;
  logic     dec_st_p;
  logic     dec_period;
  logic     dec_bit;
  bit_len_t bit_idx;

  modport src (
    output bit_strobe,
    output dec_st_p,
    output dec_period,
    output dec_bit,
    output bit_idx
  );

  modport snk (
    input bit_strobe,
    input dec_st_p,
    input dec_period,
    input dec_bit,
    input bit_idx
  );

endinterface

// ==== fhs/fhs_decoder.sv ====
`timescale 1ns/1ps

module fhs_decoder (
  input  logic                     clk_6M,
  input  logic                     rstz,
  payload_bit_if.snk               bit_bus,
  input  logic                     rxfhs,
  output bt_payload_pkg::bd_lap_t  fhs_lap,
  output bt_payload_pkg::bd_uap_t  fhs_uap,
  output bt_payload_pkg::bd_nap_t  fhs_nap,
  output bt_payload_pkg::cod_t     fhs_cod,
  output bt_payload_pkg::lt_addr_t fhs_lt_addr,
  output bt_payload_pkg::fhs_clk_t fhs_clk,
  output logic                     fhs_done_p
);
  import bt_payload_pkg::*;

  logic     is_fhs;
  logic     fhs_stb;
  bit_len_t idx;
  logic     d;

  function automatic logic in_field(bit_len_t i, int lo, int hi);
    return (i >= lo) && (i <= hi);
  endfunction

  assign fhs_stb = bit_bus.bit_strobe & bit_bus.dec_period & is_fhs;
  assign idx     = bit_bus.bit_idx;
  assign d       = bit_bus.dec_bit;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      is_fhs <= 1'b0;
    else if (bit_bus.dec_st_p)
      is_fhs <= rxfhs;
  end

  // fields arrive lsb first, shift in from the top
  // parity, eir and the bits between are skipped
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      fhs_lap     <= '0;
      fhs_uap     <= '0;
      fhs_nap     <= '0;
      fhs_cod     <= '0;
      fhs_lt_addr <= '0;
      fhs_clk     <= '0;
      fhs_done_p  <= 1'b0;
    end
    else
    begin
      fhs_done_p <= fhs_stb & (idx == bit_len_t'(FHS_BITS - 1));
      if (fhs_stb)
      begin
        if (in_field(idx, 34, 57))
          fhs_lap <= {d, fhs_lap[23:1]};
        else if (in_field(idx, 64, 71))
          fhs_uap <= {d, fhs_uap[7:1]};
        else if (in_field(idx, 72, 87))
          fhs_nap <= {d, fhs_nap[15:1]};
        else if (in_field(idx, 88, 111))
          fhs_cod <= {d, fhs_cod[23:1]};
        else if (in_field(idx, 112, 114))
          fhs_lt_addr <= {d, fhs_lt_addr[2:1]};
        else if (in_field(idx, 115, 140))
          fhs_clk <= {d, fhs_clk[25:1]};
      end
    end
  end

endmodule

// ==== hw/bt_payload_rx.sv ====
`timescale 1ns/1ps

module bt_payload_rx #(
  parameter int AXI_ADDR_WIDTH = 8,
  parameter int WORD_ADR_WIDTH = 8
) (
  input  logic                      clk_6M,
  input  logic                      rstz,
  input  logic                      py_st_p,
  input  logic                      py_datvalid_p,
  input  logic                      rxbit,
  input  logic                      rxfhs,
  // register bus
  input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [31:0]               wdata,
  input  logic [3:0]                wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [31:0]               rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  // receive buffer
  output logic [31:0]               rxpydin,
  output logic [WORD_ADR_WIDTH-1:0] rxpyadr,
  output logic                      rxpydin_valid_p_wr
);
  import bt_payload_pkg::*;

  whiten_seed_t whiten_seed;
  bd_uap_t      uap;
  logic         crc_en;
  logic         hdr_en;
  logic         single_slot;
  bit_len_t     pylenbit;
  llid_t        dec_llid;
  logic         dec_flow;
  pylen_byte_t  dec_pylen_byte;
  logic         crc_good;
  logic         done_p;
  bd_lap_t      fhs_lap;
  bd_uap_t      fhs_uap;
  bd_nap_t      fhs_nap;
  cod_t         fhs_cod;
  lt_addr_t     fhs_lt_addr;
  fhs_clk_t     fhs_clk;
  logic         fhs_done_p;

  payload_bit_if bit_bus ();

  payload_bit_ctrl #(
    .WORD_ADR_WIDTH (WORD_ADR_WIDTH)
  ) u_bit_ctrl (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .py_st_p            (py_st_p),
    .py_datvalid_p      (py_datvalid_p),
    .rxbit              (rxbit),
    .whiten_seed        (whiten_seed),
    .uap                (uap),
    .crc_en             (crc_en),
    .hdr_en             (hdr_en),
    .single_slot        (single_slot),
    .pylenbit           (pylenbit),
    .bit_bus            (bit_bus.src),
    .rxpydin            (rxpydin),
    .rxpyadr            (rxpyadr),
    .rxpydin_valid_p_wr (rxpydin_valid_p_wr),
    .dec_llid           (dec_llid),
    .dec_flow           (dec_flow),
    .dec_pylen_byte     (dec_pylen_byte),
    .crc_good           (crc_good),
    .done_p             (done_p)
  );

  fhs_decoder u_fhs_decoder (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .bit_bus     (bit_bus.snk),
    .rxfhs       (rxfhs),
    .fhs_lap     (fhs_lap),
    .fhs_uap     (fhs_uap),
    .fhs_nap     (fhs_nap),
    .fhs_cod     (fhs_cod),
    .fhs_lt_addr (fhs_lt_addr),
    .fhs_clk     (fhs_clk),
    .fhs_done_p  (fhs_done_p)
  );

  payload_regs #(
    .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH)
  ) u_regs (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wstrb          (wstrb),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .whiten_seed    (whiten_seed),
    .uap            (uap),
    .crc_en         (crc_en),
    .hdr_en         (hdr_en),
    .single_slot    (single_slot),
    .pylenbit       (pylenbit),
    .py_st_p        (py_st_p),
    .done_p         (done_p),
    .crc_good       (crc_good),
    .dec_llid       (dec_llid),
    .dec_flow       (dec_flow),
    .dec_pylen_byte (dec_pylen_byte),
    .fhs_lap        (fhs_lap),
    .fhs_uap        (fhs_uap),
    .fhs_nap        (fhs_nap),
    .fhs_cod        (fhs_cod),
    .fhs_lt_addr    (fhs_lt_addr),
    .fhs_clk        (fhs_clk),
    .fhs_done_p     (fhs_done_p)
  );

endmodule

// ==== hw/payload_bit_ctrl.sv ====
`timescale 1ns/1ps

module payload_bit_ctrl #(
  parameter int WORD_ADR_WIDTH = 8
) (
  input  logic                         clk_6M,
  input  logic                         rstz,
  input  logic                         py_st_p,
  input  logic                         py_datvalid_p,
  input  logic                         rxbit,
  input  bt_payload_pkg::whiten_seed_t whiten_seed,
  input  bt_payload_pkg::bd_uap_t      uap,
  input  logic                         crc_en,
  input  logic                         hdr_en,
  input  logic                         single_slot,
  input  bt_payload_pkg::bit_len_t     pylenbit,
  payload_bit_if.src                   bit_bus,
  output logic [31:0]                  rxpydin,
  output logic [WORD_ADR_WIDTH-1:0]    rxpyadr,
  output logic                         rxpydin_valid_p_wr,
  output bt_payload_pkg::llid_t        dec_llid,
  output logic                         dec_flow,
  output bt_payload_pkg::pylen_byte_t  dec_pylen_byte,
  output logic                         crc_good,
  output logic                         done_p
);
  import bt_payload_pkg::*;

  bit_len_t   total_len;
  bit_len_t   bit_cnt;
  logic       dec_period;
  logic       dec_st_p;
  logic       bit_stb;
  logic       data_stb;
  logic       last_bit_p;
  logic       dec_bit;
  logic       hdr_len_stb;
  logic [3:0] len_pos;
  logic [4:0] word_cnt;
  logic       pad_active;
  logic       word_shift;

  assign total_len  = crc_en ? pylenbit + bit_len_t'(CRC_BITS) : pylenbit;
  assign bit_stb    = py_datvalid_p & dec_period;
  assign data_stb   = bit_stb & (bit_cnt < pylenbit);
  assign last_bit_p = bit_stb & (bit_cnt == total_len - 1'b1);

  ////////////////////
  // period and bit count
  ////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      dec_st_p   <= 1'b0;
      dec_period <= 1'b0;
      bit_cnt    <= '0;
      done_p     <= 1'b0;
    end
    else
    begin
      dec_st_p <= py_st_p;
      done_p   <= last_bit_p;
      if (py_st_p)
        dec_period <= (pylenbit != '0);
      else if (last_bit_p)
        dec_period <= 1'b0;
      if (py_st_p)
        bit_cnt <= '0;
      else if (bit_stb)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  payload_pypro u_pypro (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .start_p     (py_st_p),
    .bit_strobe  (bit_stb),
    .rxbit       (rxbit),
    .whiten_seed (whiten_seed),
    .uap         (uap),
    .crc_en      (crc_en),
    .last_bit_p  (last_bit_p),
    .dec_bit     (dec_bit),
    .crc_good    (crc_good)
  );

  assign bit_bus.bit_strobe = bit_stb;
  assign bit_bus.dec_st_p   = dec_st_p;
  assign bit_bus.dec_period = dec_period;
  assign bit_bus.dec_bit    = dec_bit;
  assign bit_bus.bit_idx    = bit_cnt;

  ////////////////////
  // payload header
  ////////////////////

  // length field lsb first, 5 or 10 bits
  assign hdr_len_stb = data_stb & hdr_en & (bit_cnt >= 13'd3)
                       & (bit_cnt <= (single_slot ? 13'd7 : 13'd12));
  assign len_pos     = 4'(bit_cnt - 13'd3);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      dec_llid       <= '0;
      dec_flow       <= 1'b0;
      dec_pylen_byte <= '0;
    end
    else if (py_st_p)
      dec_pylen_byte <= '0;
    else if (data_stb && hdr_en)
    begin
      if (bit_cnt == 13'd0)
        dec_llid[0] <= dec_bit;
      if (bit_cnt == 13'd1)
        dec_llid[1] <= dec_bit;
      if (bit_cnt == 13'd2)
        dec_flow <= dec_bit;
      if (hdr_len_stb)
        dec_pylen_byte[len_pos] <= dec_bit;
    end
  end

  ////////////////////
  // word packing
  ////////////////////

  assign word_shift = data_stb | pad_active;

  // first bit ends up in bit 0 after 32 shifts
  always_ff @(posedge clk_6M)
  begin
    if (word_shift)
      rxpydin <= {pad_active ? 1'b0 : dec_bit, rxpydin[31:1]};
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      word_cnt   <= '0;
      pad_active <= 1'b0;
    end
    else if (py_st_p)
    begin
      word_cnt   <= '0;
      pad_active <= 1'b0;
    end
    else
    begin
      if (word_shift)
        word_cnt <= word_cnt + 1'b1;
      // partial word left at the end, zero fill it
      if (last_bit_p && (data_stb ? word_cnt != 5'd31 : word_cnt != 5'd0))
        pad_active <= 1'b1;
      else if (pad_active && word_cnt == 5'd31)
        pad_active <= 1'b0;
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rxpydin_valid_p_wr <= 1'b0;
      rxpyadr            <= '0;
    end
    else
    begin
      rxpydin_valid_p_wr <= word_shift & (word_cnt == 5'd31);
      if (py_st_p)
        rxpyadr <= '0;
      else if (rxpydin_valid_p_wr)
        rxpyadr <= rxpyadr + 1'b1;
    end
  end

endmodule

// ==== hw/payload_regs.sv ====
`timescale 1ns/1ps

module payload_regs #(
  parameter int AXI_ADDR_WIDTH = 8
) (
  input  logic                         clk_6M,
  input  logic                         rstz,
  // axi4-lite slave
  input  logic [AXI_ADDR_WIDTH-1:0]    awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [31:0]                  wdata,
  input  logic [3:0]                   wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [AXI_ADDR_WIDTH-1:0]    araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [31:0]                  rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready,
  // configuration
  output bt_payload_pkg::whiten_seed_t whiten_seed,
  output bt_payload_pkg::bd_uap_t      uap,
  output logic                         crc_en,
  output logic                         hdr_en,
  output logic                         single_slot,
  output bt_payload_pkg::bit_len_t     pylenbit,
  // status from both decoders
  input  logic                         py_st_p,
  input  logic                         done_p,
  input  logic                         crc_good,
  input  bt_payload_pkg::llid_t        dec_llid,
  input  logic                         dec_flow,
  input  bt_payload_pkg::pylen_byte_t  dec_pylen_byte,
  input  bt_payload_pkg::bd_lap_t      fhs_lap,
  input  bt_payload_pkg::bd_uap_t      fhs_uap,
  input  bt_payload_pkg::bd_nap_t      fhs_nap,
  input  bt_payload_pkg::cod_t         fhs_cod,
  input  bt_payload_pkg::lt_addr_t     fhs_lt_addr,
  input  bt_payload_pkg::fhs_clk_t     fhs_clk,
  input  logic                         fhs_done_p
);
  import bt_payload_pkg::*;

  typedef enum logic {W_IDLE, W_RESP} wr_state_t;
  typedef enum logic {R_IDLE, R_DATA} rd_state_t;

  wr_state_t   wr_state;
  rd_state_t   rd_state;
  logic        wr_en;
  logic        rd_en;
  logic        done_flag;
  logic        fhs_valid;
  logic [31:0] rd_word;

  assign wr_en   = awvalid & wvalid & (wr_state == W_IDLE);
  assign awready = wr_en;
  assign wready  = wr_en;
  assign bvalid  = (wr_state == W_RESP);
  assign bresp   = 2'b00;

  assign rd_en   = arvalid & (rd_state == R_IDLE);
  assign arready = rd_en;
  assign rvalid  = (rd_state == R_DATA);
  assign rresp   = 2'b00;

  ////////////////////
  // handshake fsms
  ////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      wr_state <= W_IDLE;
      rd_state <= R_IDLE;
    end
    else
    begin
      case (wr_state)
        W_IDLE: if (wr_en) wr_state <= W_RESP;
        W_RESP: if (bready) wr_state <= W_IDLE;
        default: wr_state <= W_IDLE;
      endcase
      case (rd_state)
        R_IDLE: if (rd_en) rd_state <= R_DATA;
        R_DATA: if (rready) rd_state <= R_IDLE;
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  ////////////////////
  // config registers
  ////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      whiten_seed <= '0;
      uap         <= '0;
      crc_en      <= 1'b0;
      hdr_en      <= 1'b0;
      single_slot <= 1'b0;
      pylenbit    <= '0;
    end
    else if (wr_en && awaddr == AXI_ADDR_WIDTH'(REG_CTRL))
    begin
      if (wstrb[0])
        whiten_seed <= wdata[6:0];
      if (wstrb[1])
        uap <= wdata[15:8];
      if (wstrb[2])
        {single_slot, hdr_en, crc_en} <= wdata[18:16];
    end
    else if (wr_en && awaddr == AXI_ADDR_WIDTH'(REG_LEN))
    begin
      if (wstrb[0])
        pylenbit[7:0] <= wdata[7:0];
      if (wstrb[1])
        pylenbit[12:8] <= wdata[12:8];
    end
  end

  // sticky flags, cleared when a new payload starts
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      done_flag <= 1'b0;
      fhs_valid <= 1'b0;
    end
    else if (py_st_p)
    begin
      done_flag <= 1'b0;
      fhs_valid <= 1'b0;
    end
    else
    begin
      if (done_p)
        done_flag <= 1'b1;
      if (fhs_done_p)
        fhs_valid <= 1'b1;
    end
  end

  // read mux, unmapped offsets give zero
  always_comb
  begin
    case (araddr)
      AXI_ADDR_WIDTH'(REG_CTRL):
        rd_word = {13'b0, single_slot, hdr_en, crc_en, uap, 1'b0, whiten_seed};
      AXI_ADDR_WIDTH'(REG_LEN):
        rd_word = {19'b0, pylenbit};
      AXI_ADDR_WIDTH'(REG_STATUS):
        rd_word = {14'b0, dec_pylen_byte, 2'b0, dec_flow, dec_llid,
                   fhs_valid, crc_good, done_flag};
      AXI_ADDR_WIDTH'(REG_FHS_LAP):
        rd_word = {8'b0, fhs_lap};
      AXI_ADDR_WIDTH'(REG_FHS_UAP_NAP):
        rd_word = {8'b0, fhs_nap, fhs_uap};
      AXI_ADDR_WIDTH'(REG_FHS_COD):
        rd_word = {8'b0, fhs_cod};
      AXI_ADDR_WIDTH'(REG_FHS_LT_CLK):
        rd_word = {3'b0, fhs_lt_addr, fhs_clk};
      default:
        rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_6M)
  begin
    if (rd_en)
      rdata <= rd_word;
  end

endmodule

// ==== pypro/payload_pypro.sv ====
`timescale 1ns/1ps

module payload_pypro (
  input  logic                         clk_6M,
  input  logic                         rstz,
  input  logic                         start_p,
  input  logic                         bit_strobe,
  input  logic                         rxbit,
  input  bt_payload_pkg::whiten_seed_t whiten_seed,
  input  bt_payload_pkg::bd_uap_t      uap,
  input  logic                         crc_en,
  input  logic                         last_bit_p,
  output logic                         dec_bit,
  output logic                         crc_good
);
  import bt_payload_pkg::*;

  // ccitt x^16+x^12+x^5+1
  localparam logic [CRC_BITS-1:0] CRC_POLY = 16'h1021;

  whiten_seed_t        lfsr;
  logic [CRC_BITS-1:0] crc_q;
  logic [CRC_BITS-1:0] crc_next;
  logic                crc_fb;

  // dewhitening is combinational on the air bit
  assign dec_bit = rxbit ^ lfsr[6];

  assign crc_fb   = crc_q[CRC_BITS-1] ^ dec_bit;
  assign crc_next = {crc_q[CRC_BITS-2:0], 1'b0} ^ (crc_fb ? CRC_POLY : '0);

  // whitening lfsr x^7+x^4+1, steps on data and crc bits alike
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lfsr <= '0;
    else if (start_p)
      lfsr <= whiten_seed;
    else if (bit_strobe)
      lfsr <= {lfsr[5:4], lfsr[3] ^ lfsr[6], lfsr[2:0], lfsr[6]};
  end

  // crc register, uap in the low byte
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      crc_q <= '0;
    else if (start_p)
      crc_q <= {8'h00, uap};
    else if (bit_strobe)
      crc_q <= crc_next;
  end

  // remainder checked with the last bit included
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      crc_good <= 1'b0;
    else if (start_p)
      crc_good <= 1'b0;
    else if (last_bit_p)
      crc_good <= crc_en ? (crc_next == '0) : 1'b1;
  end

endmodule

// ==== testbench/tb_bt_payload_rx.sv ====
`timescale 1ns/1ps

module tb_bt_payload_rx;
  import bt_payload_pkg::*;

  localparam int AW         = 8;
  // every packet of the run with its crc
  localparam int TOTAL_BITS = 2 * (256 + 16) + (144 + 16) + (77 + 16);
  localparam int MAX_CYCLES = TOTAL_BITS * 6 + 4000;

  logic          clk_6M;
  logic          rstz;
  logic          py_st_p;
  logic          py_datvalid_p;
  logic          rxbit;
  logic          rxfhs;
  logic [AW-1:0] awaddr;
  logic          awvalid;
  logic          awready;
  logic [31:0]   wdata;
  logic [3:0]    wstrb;
  logic          wvalid;
  logic          wready;
  logic [1:0]    bresp;
  logic          bvalid;
  logic          bready;
  logic [AW-1:0] araddr;
  logic          arvalid;
  logic          arready;
  logic [31:0]   rdata;
  logic [1:0]    rresp;
  logic          rvalid;
  logic          rready;
  logic [31:0]   rxpydin;
  logic [7:0]    rxpyadr;
  logic          rxpydin_valid_p_wr;

  logic [31:0] rng;
  logic        dec_bits [512];
  int          n_data;
  int          n_total;
  logic [31:0] got_word [$];
  logic [7:0]  got_adr [$];
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          cycles;

  bt_payload_rx #(
    .AXI_ADDR_WIDTH (AW),
    .WORD_ADR_WIDTH (8)
  ) UUT (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .py_st_p            (py_st_p),
    .py_datvalid_p      (py_datvalid_p),
    .rxbit              (rxbit),
    .rxfhs              (rxfhs),
    .awaddr             (awaddr),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wvalid             (wvalid),
    .wready             (wready),
    .bresp              (bresp),
    .bvalid             (bvalid),
    .bready             (bready),
    .araddr             (araddr),
    .arvalid            (arvalid),
    .arready            (arready),
    .rdata              (rdata),
    .rresp              (rresp),
    .rvalid             (rvalid),
    .rready             (rready),
    .rxpydin            (rxpydin),
    .rxpyadr            (rxpyadr),
    .rxpydin_valid_p_wr (rxpydin_valid_p_wr)
  );

  initial
  begin
    clk_6M = 1'b0;
    forever #5 clk_6M = ~clk_6M;
  end

  always @(posedge clk_6M)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run did not end within %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // receive buffer writes
  always @(posedge clk_6M)
  begin
    if (rstz && rxpydin_valid_p_wr)
    begin
      got_word.push_back(rxpydin);
      got_adr.push_back(rxpyadr);
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    logic b;
    b = rng[0];
    rng = lfsr_step(rng);
    return b;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [AW-1:0] addr, input logic [31:0] data,
                           input int hold);
    @(posedge clk_6M);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    @(posedge clk_6M);
    while (!(awready && wready))
      @(posedge clk_6M);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk_6M);
    while (!bvalid)
      @(posedge clk_6M);
    // response must wait for bready
    repeat (hold)
    begin
      @(posedge clk_6M);
      check_value("bvalid held", bvalid, 1'b1);
    end
    check_value("bresp", bresp, 2'b00);
    bready <= 1'b1;
    @(posedge clk_6M);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [AW-1:0] addr, output logic [31:0] data,
                          input int hold);
    @(posedge clk_6M);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge clk_6M);
    while (!arready)
      @(posedge clk_6M);
    arvalid <= 1'b0;
    @(posedge clk_6M);
    while (!rvalid)
      @(posedge clk_6M);
    repeat (hold)
    begin
      @(posedge clk_6M);
      check_value("rvalid held", rvalid, 1'b1);
    end
    data = rdata;
    check_value("rresp", rresp, 2'b00);
    rready <= 1'b1;
    @(posedge clk_6M);
    rready <= 1'b0;
  endtask

  task automatic configure(input logic [6:0] seed, input logic [7:0] uap,
                           input logic crc_en, input logic hdr_en,
                           input logic single_slot, input int len);
    write_reg(REG_CTRL, {13'b0, single_slot, hdr_en, crc_en, uap, 1'b0, seed}, 0);
    write_reg(REG_LEN, 32'(len), 0);
  endtask

  task automatic fill_random(input int n);
    n_data = n;
    for (int k = 0; k < n; k++)
      dec_bits[k] = rand_bit();
  endtask

  // field goes out lsb first
  task automatic put_field(input int pos, input int width, input logic [31:0] value);
    for (int i = 0; i < width; i++)
      dec_bits[pos + i] = value[i];
  endtask

  // ccitt crc over the data with the remainder sent msb first
  task automatic append_crc(input logic [7:0] uap);
    logic [15:0] crc;
    logic        fb;
    crc = {8'h00, uap};
    for (int k = 0; k < n_data; k++)
    begin
      fb  = crc[15] ^ dec_bits[k];
      crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    end
    for (int i = 0; i < 16; i++)
      dec_bits[n_data + i] = crc[15 - i];
    n_total = n_data + 16;
  endtask

  // whitens on the fly with one strobe every 6 clocks
  task automatic send_packet(input logic fhs, input logic [6:0] seed);
    logic [6:0] w;
    logic       fb;
    w = seed;
    @(posedge clk_6M);
    py_st_p <= 1'b1;
    rxfhs   <= fhs;
    @(posedge clk_6M);
    py_st_p <= 1'b0;
    for (int k = 0; k < n_total; k++)
    begin
      repeat (5) @(posedge clk_6M);
      py_datvalid_p <= 1'b1;
      rxbit         <= dec_bits[k] ^ w[6];
      fb   = w[6];
      w    = {w[5:0], fb};
      w[4] = w[4] ^ fb;
      @(posedge clk_6M);
      py_datvalid_p <= 1'b0;
    end
    rxfhs <= 1'b0;
  endtask

  task automatic wait_done(output logic [31:0] status);
    int polls;
    polls = 0;
    do
    begin
      read_reg(REG_STATUS, status, 0);
      polls++;
    end
    while (!status[0] && polls < 50);
    assert (status[0])
    else
    begin
      $display("done flag never set in STATUS after %0d reads", polls);
      errors++;
    end
  endtask

  function automatic logic [31:0] expected_word(input int j);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++)
      if (32 * j + i < n_data)
        w[i] = dec_bits[32 * j + i];
    return w;
  endfunction

  task automatic run_packet(input logic fhs, input logic [6:0] seed,
                            output logic [31:0] status);
    int exp_words;
    exp_words = (n_data + 31) / 32;
    got_word.delete();
    got_adr.delete();
    send_packet(fhs, seed);
    wait_done(status);
    while (got_word.size() < exp_words)
      @(posedge clk_6M);
    repeat (4) @(posedge clk_6M);
    check_value("word count", got_word.size(), exp_words);
    for (int j = 0; j < exp_words && j < got_word.size(); j++)
    begin
      check_value($sformatf("word %0d", j), got_word[j], expected_word(j));
      check_value($sformatf("address of word %0d", j), got_adr[j], j);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before)
    begin
      tests_passed++;
      $display("test %s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    logic [31:0] rd;
    logic [31:0] st;
    int          e0;

    rstz          = 1'b0;
    py_st_p       = 1'b0;
    py_datvalid_p = 1'b0;
    rxbit         = 1'b0;
    rxfhs         = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    rng           = 32'h1dbe3b67;
    errors        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    cycles        = 0;
    n_data        = 0;
    n_total       = 0;

    repeat (16) @(posedge clk_6M);
    rstz <= 1'b1;
    @(posedge clk_6M);

    // outputs idle after reset
    e0 = errors;
    @(posedge clk_6M);
    check_value("awready after reset", awready, 1'b0);
    check_value("wready after reset", wready, 1'b0);
    check_value("arready after reset", arready, 1'b0);
    check_value("bvalid after reset", bvalid, 1'b0);
    check_value("rvalid after reset", rvalid, 1'b0);
    check_value("write pulse after reset", rxpydin_valid_p_wr, 1'b0);
    read_reg(REG_STATUS, rd, 0);
    check_value("STATUS after reset", rd, 32'h0);
    read_reg(8'h40, rd, 0);
    check_value("unmapped 0x40", rd, 32'h0);
    read_reg(8'h1C, rd, 0);
    check_value("unmapped 0x1C", rd, 32'h0);
    report_test("reset", e0);

    e0 = errors;
    write_reg(REG_CTRL, 32'h0005A55A, 3);
    write_reg(REG_LEN, 32'h00001ABC, 3);
    read_reg(REG_CTRL, rd, 3);
    check_value("CTRL readback", rd, 32'h0005A55A);
    read_reg(REG_LEN, rd, 3);
    check_value("LEN readback", rd, 32'h00001ABC);
    report_test("register readback", e0);

    // multi-slot packet with llid 2 flow 1 and 30 bytes
    e0 = errors;
    configure(7'h4B, 8'h47, 1'b1, 1'b1, 1'b0, 256);
    fill_random(256);
    put_field(0, 2, 2'b10);
    put_field(2, 1, 1'b1);
    put_field(3, 10, 10'd30);
    append_crc(8'h47);
    run_packet(1'b0, 7'h4B, st);
    check_value("STATUS crc packet", st,
                {14'b0, 10'd30, 2'b0, 1'b1, 2'b10, 1'b0, 1'b1, 1'b1});
    report_test("crc packet", e0);

    e0 = errors;
    dec_bits[n_data + 5] = ~dec_bits[n_data + 5];
    run_packet(1'b0, 7'h4B, st);
    check_value("STATUS crc error", st,
                {14'b0, 10'd30, 2'b0, 1'b1, 2'b10, 1'b0, 1'b0, 1'b1});
    report_test("crc error", e0);

    // fhs payload with known fields
    e0 = errors;
    configure(7'h35, 8'h9A, 1'b1, 1'b0, 1'b0, 144);
    fill_random(144);
    put_field(34, 24, 24'h9E8B33);
    put_field(64, 8, 8'h5C);
    put_field(72, 16, 16'hC0DE);
    put_field(88, 24, 24'h5A020C);
    put_field(112, 3, 3'b110);
    put_field(115, 26, 26'h1234567);
    append_crc(8'h9A);
    run_packet(1'b1, 7'h35, st);
    check_value("STATUS fhs flags", st[2:0], 3'b111);
    read_reg(REG_FHS_LAP, rd, 0);
    check_value("FHS LAP", rd, 32'h009E8B33);
    read_reg(REG_FHS_UAP_NAP, rd, 0);
    check_value("FHS UAP/NAP", rd, {8'h00, 16'hC0DE, 8'h5C});
    read_reg(REG_FHS_COD, rd, 0);
    check_value("FHS CoD", rd, 32'h005A020C);
    read_reg(REG_FHS_LT_CLK, rd, 0);
    check_value("FHS LT_ADDR/CLK", rd, {3'b0, 3'b110, 26'h1234567});
    report_test("fhs packet", e0);

    // 77 bits so the last word holds 13
    e0 = errors;
    configure(7'h61, 8'h2E, 1'b1, 1'b1, 1'b1, 77);
    fill_random(77);
    put_field(0, 2, 2'b01);
    put_field(2, 1, 1'b0);
    put_field(3, 5, 5'd7);
    append_crc(8'h2E);
    run_packet(1'b0, 7'h61, st);
    check_value("STATUS partial word", st,
                {14'b0, 10'd7, 2'b0, 1'b0, 2'b01, 1'b0, 1'b1, 1'b1});
    if (got_word.size() == 3)
      check_value("zero fill of last word", got_word[2][31:13], 19'h0);
    report_test("partial word", e0);

    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
